/* hdl/bubl_pkg.sv */
// Bubble Bobble memory side shared widths, ROM map and variant constants
`default_nettype none

package bubl_pkg;

    // SDRAM word channel
    localparam int SDRAM_AW = 22;        // Word address
    localparam int SDRAM_DW = 16;        // Read word

    // Byte-wide ROM download
    localparam int IOCTL_AW = 25;

    // CPU ROM port byte address widths
    localparam int MAIN_AW = 18;         // Main Z80, banked
    localparam int SUB_AW  = 15;         // Sub Z80
    localparam int MCU_AW  = 12;         // 6801 internal ROM
    localparam int SND_AW  = 15;         // Sound Z80

    // Region starts in the ROM image, in bytes
    localparam logic [SDRAM_AW-1:0] SUB_START = 22'h2_8000;
    localparam logic [SDRAM_AW-1:0] SND_START = 22'h3_0000;
    localparam logic [SDRAM_AW-1:0] MCU_START = 22'h3_8000;

    // Same regions as SDRAM word offsets
    localparam logic [SDRAM_AW-1:0] MAIN_OFFSET = '0;
    localparam logic [SDRAM_AW-1:0] SUB_OFFSET  = SUB_START >> 1;
    localparam logic [SDRAM_AW-1:0] MCU_OFFSET  = MCU_START >> 1;
    localparam logic [SDRAM_AW-1:0] SND_OFFSET  = SND_START >> 1;

    // Colour PROMs follow the CPU and graphics ROMs in the image and
    // never reach the SDRAM
    localparam logic [IOCTL_AW-1:0] PROM_START = 25'hC_0000;

    // Both Tokio sets open with this byte, Bubble Bobble does not
    localparam logic [7:0] TOKIO_ID = 8'h7e;

    // Slots sharing the SDRAM read channel
    localparam int NSLOTS = 4;

endpackage

`default_nettype wire

/* hdl/bubl_cen.sv */
// Clock enable generator giving 12, 6, 4 and 3 MHz strobes from 24 MHz
`timescale 1ns/100ps
`default_nettype none

module bubl_cen (
    input  wire  clk,
    input  wire  rst24,
    output logic cen12,
    output logic cen6,
    output logic cen4,
    output logic cen3
);

    logic [4:0] cnt;    // 24 is the common multiple of 2, 4, 6, 8

    // Decodes sit on the last count of each period so that
    // nothing fires in the first cycle out of reset
    always_ff @(posedge clk or posedge rst24) begin
        if (rst24) begin
            cnt   <= '0;
            cen12 <= 1'b0;
            cen6  <= 1'b0;
            cen4  <= 1'b0;
            cen3  <= 1'b0;
        end else begin
            cnt   <= (cnt == 5'd23) ? 5'd0 : cnt + 5'd1;
            cen12 <= (cnt % 2) == 1;
            cen6  <= (cnt % 4) == 3;
            cen4  <= (cnt % 6) == 5;
            cen3  <= (cnt % 8) == 7;
        end
    end

    // Pixel clock enables must stay phase aligned
    assert property (@(posedge clk) disable iff (rst24) cen6 |-> cen12);

endmodule

`default_nettype wire

/* hdl/bubl_dwnld.sv */
// ROM download adapter turning the byte stream into SDRAM writes and PROM strobes
`timescale 1ns/100ps
`default_nettype none

module bubl_dwnld (
    input  wire                          clk,
    input  wire                          rst24,
    input  wire                          downloading,
    input  wire  [bubl_pkg::IOCTL_AW-1:0] ioctl_addr,
    input  wire  [7:0]                   ioctl_dout,
    input  wire                          ioctl_wr,
    input  wire                          sdram_ack,
    output logic [bubl_pkg::SDRAM_AW-1:0] prog_addr,
    output logic [7:0]                   prog_data,
    output logic [1:0]                   prog_mask,
    output logic                         prog_we,
    output logic                         prom_we
);

    import bubl_pkg::*;

    logic wr_valid;
    logic is_prom;

    assign wr_valid = ioctl_wr && downloading;
    assign is_prom  = ioctl_addr >= PROM_START;

    // Write data and byte lane, shared by SDRAM and PROM paths
    always_ff @(posedge clk) begin
        if (wr_valid) begin
            prog_addr <= ioctl_addr[SDRAM_AW:1];
            prog_data <= ioctl_dout;
            prog_mask <= ioctl_addr[0] ? 2'b01 : 2'b10;   // Active low
        end
    end

    always_ff @(posedge clk or posedge rst24) begin
        if (rst24) begin
            prog_we <= 1'b0;
            prom_we <= 1'b0;
        end else begin
            prom_we <= 1'b0;
            if (sdram_ack)
                prog_we <= 1'b0;        // Controller took the word
            if (wr_valid) begin
                if (is_prom)
                    prom_we <= 1'b1;    // Single strobe
                else
                    prog_we <= 1'b1;    // Held until ack
            end
        end
    end

    // The loader must pace its bytes to the SDRAM acknowledge
    assert property (@(posedge clk) disable iff (rst24)
        ioctl_wr |-> !prog_we || sdram_ack);

endmodule

`default_nettype wire

/* hdl/bubl_rom_slot.sv */
// One-word ROM cache for a CPU port, fetching misses through the SDRAM arbiter
`timescale 1ns/100ps
`default_nettype none

module bubl_rom_slot #(
    parameter int                            AW     = 15,
    parameter logic [bubl_pkg::SDRAM_AW-1:0] OFFSET = '0
) (
    input  wire                          clk,
    input  wire                          rst24,
    input  wire                          cs,
    input  wire  [AW-1:0]                addr,
    output logic                         ok,
    output logic [7:0]                   data,
    output logic                         req,
    output logic [bubl_pkg::SDRAM_AW-1:0] req_addr,
    input  wire                          grant,
    input  wire                          rdy,
    input  wire  [bubl_pkg::SDRAM_DW-1:0] rdata
);

    import bubl_pkg::*;

    logic [SDRAM_DW-1:0] word;          // Cached word
    logic [AW-2:0]       word_addr;     // Its word address in the region
    logic                valid;
    logic [AW-2:0]       fetch_addr;    // Address of the read in progress
    logic                granted;       // Read accepted, data on its way
    logic                hit;

    assign hit  = valid && (word_addr == addr[AW-1:1]);
    assign ok   = cs && hit;
    assign data = addr[0] ? word[15:8] : word[7:0];

    assign req_addr = OFFSET + SDRAM_AW'(fetch_addr);

    always_ff @(posedge clk) begin
        if (!req && cs && !hit)
            fetch_addr <= addr[AW-1:1];
        if (granted && rdy) begin
            word      <= rdata;
            word_addr <= fetch_addr;
        end
    end

    // Idle, requesting, then waiting for the word
    always_ff @(posedge clk or posedge rst24) begin
        if (rst24) begin
            req     <= 1'b0;
            granted <= 1'b0;
            valid   <= 1'b0;
        end else begin
            if (!req) begin
                if (cs && !hit)
                    req <= 1'b1;
            end else if (!granted) begin
                if (grant)
                    granted <= 1'b1;
            end else if (rdy) begin
                req     <= 1'b0;
                granted <= 1'b0;
                valid   <= 1'b1;
            end
        end
    end

    // Only one read is in flight, so the next rdy belongs to this grant
    assert property (@(posedge clk) disable iff (rst24)
        grant |-> req until_with rdy);

endmodule

`default_nettype wire

/* hdl/bubl_rom_arb.sv */
// Round-robin arbiter sharing the single-request SDRAM read channel among ROM slots
`timescale 1ns/100ps
`default_nettype none

module bubl_rom_arb (
    input  wire                          clk,
    input  wire                          rst24,
    input  wire                          downloading,
    input  wire  [bubl_pkg::NSLOTS-1:0]  req,
    input  wire  [bubl_pkg::SDRAM_AW-1:0] req_addr0,
    input  wire  [bubl_pkg::SDRAM_AW-1:0] req_addr1,
    input  wire  [bubl_pkg::SDRAM_AW-1:0] req_addr2,
    input  wire  [bubl_pkg::SDRAM_AW-1:0] req_addr3,
    output logic [bubl_pkg::NSLOTS-1:0]  grant,
    output logic                         rdy,
    output logic [bubl_pkg::SDRAM_DW-1:0] rdata,
    output logic                         sdram_req,
    output logic [bubl_pkg::SDRAM_AW-1:0] sdram_addr,
    input  wire                          sdram_ack,
    input  wire                          data_rdy,
    input  wire  [bubl_pkg::SDRAM_DW-1:0] data_read
);

    import bubl_pkg::*;

    localparam int SW = $clog2(NSLOTS);

    logic          req_q;       // Request presented to the SDRAM
    logic          busy;        // Accepted, data not back yet
    logic [SW-1:0] sel;         // Slot owning the current read
    logic [SW-1:0] last;        // Last slot granted
    logic [SW-1:0] pick;
    logic          pick_vld;
    logic [SW-1:0] rr_idx;
    logic [SDRAM_AW-1:0] pick_addr;
    logic          start;

    // Search from the slot after the last grant, nearest one wins
    always_comb begin
        pick_vld = 1'b0;
        pick     = last;
        rr_idx   = last;
        for (int i = NSLOTS; i >= 1; i--) begin
            rr_idx = SW'((int'(last) + i) % NSLOTS);
            if (req[rr_idx]) begin
                pick_vld = 1'b1;
                pick     = rr_idx;
            end
        end
    end

    always_comb begin
        case (pick)
            2'd0:    pick_addr = req_addr0;
            2'd1:    pick_addr = req_addr1;
            2'd2:    pick_addr = req_addr2;
            default: pick_addr = req_addr3;
        endcase
    end

    assign start     = !req_q && !busy && !downloading && pick_vld;
    assign sdram_req = req_q && !downloading;   // Download owns the bus
    assign grant     = (sdram_req && sdram_ack) ? {{(NSLOTS-1){1'b0}}, 1'b1} << sel : '0;
    assign rdy       = busy && data_rdy;
    assign rdata     = data_read;

    always_ff @(posedge clk) begin
        if (start)
            sdram_addr <= pick_addr;
    end

    always_ff @(posedge clk or posedge rst24) begin
        if (rst24) begin
            req_q <= 1'b0;
            busy  <= 1'b0;
            sel   <= '0;
            last  <= SW'(NSLOTS - 1);  // First search starts at slot 0
        end else begin
            if (sdram_req && sdram_ack) begin
                req_q <= 1'b0;
                busy  <= 1'b1;
                last  <= sel;
            end else if (req_q && downloading) begin
                req_q <= 1'b0;          // Withdrawn, slot asks again later
            end else if (start) begin
                req_q <= 1'b1;
                sel   <= pick;
            end
            if (rdy)
                busy <= 1'b0;
        end
    end

    assert property (@(posedge clk) disable iff (rst24)
        |grant |=> (grant == '0) until_with data_rdy);

    // No pending read survives into a download
    assert property (@(posedge clk) disable iff (rst24)
        downloading ##1 downloading |-> !req_q);

endmodule

`default_nettype wire

/* hdl/bubl_game.sv */
// Bubble Bobble game core memory side with ROM load, CPU ROM slots and start control
`timescale 1ns/100ps
`default_nettype none

module bubl_game (
    input  wire                          clk,
    input  wire                          rst24,
    // ROM download
    input  wire                          downloading,
    input  wire  [bubl_pkg::IOCTL_AW-1:0] ioctl_addr,
    input  wire  [7:0]                   ioctl_dout,
    input  wire                          ioctl_wr,
    output logic                         dwnld_busy,
    output logic [bubl_pkg::SDRAM_AW-1:0] prog_addr,
    output logic [7:0]                   prog_data,
    output logic [1:0]                   prog_mask,
    output logic                         prog_we,
    output logic                         prom_we,
    // SDRAM read channel
    output logic                         sdram_req,
    output logic [bubl_pkg::SDRAM_AW-1:0] sdram_addr,
    input  wire                          sdram_ack,
    input  wire                          data_rdy,
    input  wire  [bubl_pkg::SDRAM_DW-1:0] data_read,
    // CPU ROM ports
    input  wire                          main_cs,
    input  wire  [bubl_pkg::MAIN_AW-1:0] main_addr,
    output logic                         main_ok,
    output logic [7:0]                   main_data,
    input  wire                          sub_cs,
    input  wire  [bubl_pkg::SUB_AW-1:0]  sub_addr,
    output logic                         sub_ok,
    output logic [7:0]                   sub_data,
    input  wire                          mcu_cs,
    input  wire  [bubl_pkg::MCU_AW-1:0]  mcu_addr,
    output logic                         mcu_ok,
    output logic [7:0]                   mcu_data,
    input  wire                          snd_cs,
    input  wire  [bubl_pkg::SND_AW-1:0]  snd_addr,
    output logic                         snd_ok,
    output logic [7:0]                   snd_data,
    // Control
    output logic                         cpu_start,
    output logic                         tokio,
    output logic                         pxl2_cen,  // 12 MHz
    output logic                         pxl_cen,   // 6 MHz
    output logic                         cen4,
    output logic                         cen3
);

    import bubl_pkg::*;

    logic [NSLOTS-1:0]   slot_req;
    logic [NSLOTS-1:0]   slot_grant;
    logic [SDRAM_AW-1:0] main_req_addr, sub_req_addr, mcu_req_addr, snd_req_addr;
    logic                arb_rdy;
    logic [SDRAM_DW-1:0] arb_rdata;
    logic                slot_rst;

    assign dwnld_busy = downloading;
    assign slot_rst   = rst24 | downloading;    // Caches go stale while ROM is rewritten

    bubl_cen u_cen (
        .clk   ( clk      ),
        .rst24 ( rst24    ),
        .cen12 ( pxl2_cen ),
        .cen6  ( pxl_cen  ),
        .cen4  ( cen4     ),
        .cen3  ( cen3     )
    );

    bubl_dwnld u_dwnld (
        .clk         ( clk         ),
        .rst24       ( rst24       ),
        .downloading ( downloading ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_dout  ( ioctl_dout  ),
        .ioctl_wr    ( ioctl_wr    ),
        .sdram_ack   ( sdram_ack   ),
        .prog_addr   ( prog_addr   ),
        .prog_data   ( prog_data   ),
        .prog_mask   ( prog_mask   ),
        .prog_we     ( prog_we     ),
        .prom_we     ( prom_we     )
    );

    // Single byte check, both Tokio sets share it
    always_ff @(posedge clk or posedge rst24) begin
        if (rst24)
            tokio <= 1'b0;
        else if (ioctl_wr && downloading && ioctl_addr == '0)
            tokio <= ioctl_dout == TOKIO_ID;
    end

    // CPUs run once every ROM port has its first byte
    always_ff @(posedge clk or posedge rst24) begin
        if (rst24)
            cpu_start <= 1'b0;
        else if (!downloading && &{main_ok, sub_ok, mcu_ok, snd_ok})
            cpu_start <= 1'b1;
    end

    // Chip selects forced high before start to prefetch the reset vectors
    bubl_rom_slot #(.AW(MAIN_AW), .OFFSET(MAIN_OFFSET)) u_main (
        .clk ( clk ), .rst24 ( slot_rst ),
        .cs ( main_cs | ~cpu_start ), .addr ( main_addr ),
        .ok ( main_ok ), .data ( main_data ),
        .req ( slot_req[0] ), .req_addr ( main_req_addr ),
        .grant ( slot_grant[0] ), .rdy ( arb_rdy ), .rdata ( arb_rdata )
    );

    bubl_rom_slot #(.AW(SUB_AW), .OFFSET(SUB_OFFSET)) u_sub (
        .clk ( clk ), .rst24 ( slot_rst ),
        .cs ( sub_cs | ~cpu_start ), .addr ( sub_addr ),
        .ok ( sub_ok ), .data ( sub_data ),
        .req ( slot_req[1] ), .req_addr ( sub_req_addr ),
        .grant ( slot_grant[1] ), .rdy ( arb_rdy ), .rdata ( arb_rdata )
    );

    bubl_rom_slot #(.AW(MCU_AW), .OFFSET(MCU_OFFSET)) u_mcu (
        .clk ( clk ), .rst24 ( slot_rst ),
        .cs ( mcu_cs | ~cpu_start ), .addr ( mcu_addr ),
        .ok ( mcu_ok ), .data ( mcu_data ),
        .req ( slot_req[2] ), .req_addr ( mcu_req_addr ),
        .grant ( slot_grant[2] ), .rdy ( arb_rdy ), .rdata ( arb_rdata )
    );

    bubl_rom_slot #(.AW(SND_AW), .OFFSET(SND_OFFSET)) u_snd (
        .clk ( clk ), .rst24 ( slot_rst ),
        .cs ( snd_cs | ~cpu_start ), .addr ( snd_addr ),
        .ok ( snd_ok ), .data ( snd_data ),
        .req ( slot_req[3] ), .req_addr ( snd_req_addr ),
        .grant ( slot_grant[3] ), .rdy ( arb_rdy ), .rdata ( arb_rdata )
    );

    bubl_rom_arb u_arb (
        .clk         ( clk           ),
        .rst24       ( rst24         ),
        .downloading ( downloading   ),
        .req         ( slot_req      ),
        .req_addr0   ( main_req_addr ),
        .req_addr1   ( sub_req_addr  ),
        .req_addr2   ( mcu_req_addr  ),
        .req_addr3   ( snd_req_addr  ),
        .grant       ( slot_grant    ),
        .rdy         ( arb_rdy       ),
        .rdata       ( arb_rdata     ),
        .sdram_req   ( sdram_req     ),
        .sdram_addr  ( sdram_addr    ),
        .sdram_ack   ( sdram_ack     ),
        .data_rdy    ( data_rdy      ),
        .data_read   ( data_read     )
    );

endmodule

`default_nettype wire

/* testbench/sdram_model.sv */
// Behavioural SDRAM answering word reads and masked byte writes with random latency
`timescale 1ns/100ps
`default_nettype none

module sdram_model (
    input  wire                           clk,
    input  wire                           rst24,
    input  wire                           sdram_req,
    input  wire  [bubl_pkg::SDRAM_AW-1:0] sdram_addr,
    input  wire                           prog_we,
    input  wire  [bubl_pkg::SDRAM_AW-1:0] prog_addr,
    input  wire  [7:0]                    prog_data,
    input  wire  [1:0]                    prog_mask,
    output logic                          sdram_ack,
    output logic                          data_rdy,
    output logic [bubl_pkg::SDRAM_DW-1:0] data_read
);

    import bubl_pkg::*;

    logic [SDRAM_DW-1:0] mem [int];     // Only written words are stored
    int                  seed = 69;

    // Unwritten memory reads back a pattern built from the address
    function automatic logic [SDRAM_DW-1:0] fetch(input logic [SDRAM_AW-1:0] a);
        if (mem.exists(int'(a)))
            return mem[int'(a)];
        return {a[15:8] ^ 8'h5a, a[7:0]};
    endfunction

    task automatic serve;
        int                  delay;
        logic                is_write;
        logic [SDRAM_DW-1:0] w;
        delay    = 2 + ($unsigned($random(seed)) % 4);
        is_write = prog_we;
        repeat (delay - 1) @(posedge clk);
        #1;
        if (is_write ? prog_we : sdram_req) begin   // Request may be withdrawn
            sdram_ack = 1'b1;
            if (is_write) begin
                w = fetch(prog_addr);
                if (!prog_mask[0])
                    w[7:0] = prog_data;
                if (!prog_mask[1])
                    w[15:8] = prog_data;
                mem[int'(prog_addr)] = w;
            end else begin
                w = fetch(sdram_addr);
            end
            @(posedge clk);
            #1 sdram_ack = 1'b0;
            if (!is_write) begin
                repeat (2) @(posedge clk);
                #1;
                data_rdy  = 1'b1;
                data_read = w;
                @(posedge clk);
                #1 data_rdy = 1'b0;
            end
        end
    endtask

    initial begin
        sdram_ack = 1'b0;
        data_rdy  = 1'b0;
        data_read = '0;
        forever begin
            @(posedge clk);
            if (!rst24 && (prog_we || sdram_req))
                serve();
        end
    end

endmodule

`default_nettype wire

/* testbench/tb_bubl_game.sv */
// Testbench for the game memory side, checking it with concurrent assertions
`timescale 1ns/100ps
`default_nettype none

module tb_bubl_game;

    import bubl_pkg::*;

    logic clk, rst24, downloading, ioctl_wr, dwnld_busy;
    logic [IOCTL_AW-1:0] ioctl_addr;
    logic [7:0] ioctl_dout, prog_data;
    logic [SDRAM_AW-1:0] prog_addr, sdram_addr;
    logic [1:0] prog_mask;
    logic prog_we, prom_we, sdram_req, sdram_ack, data_rdy;
    logic [SDRAM_DW-1:0] data_read;
    logic main_cs, sub_cs, mcu_cs, snd_cs, main_ok, sub_ok, mcu_ok, snd_ok;
    logic [MAIN_AW-1:0] main_addr;
    logic [SUB_AW-1:0] sub_addr;
    logic [MCU_AW-1:0] mcu_addr;
    logic [SND_AW-1:0] snd_addr;
    logic [7:0] main_data, sub_data, mcu_data, snd_data;
    logic cpu_start, tokio, pxl2_cen, pxl_cen, cen4, cen3;
    logic [3:0] ok_vec;

    int seed = 69;
    int errors = 0;
    int timeouts = 0;
    logic [7:0] image [int];            // Bytes written below PROM_START

    assign ok_vec = {snd_ok, mcu_ok, sub_ok, main_ok};

    initial clk = 1'b0;
    always #2 clk = ~clk;

    bubl_game bubl_game_inst (.*);

    sdram_model sdram_inst (.*);

    function automatic logic [7:0] exp_byte(input logic [SDRAM_AW-1:0] wa, input logic lane);
        int ba;
        ba = int'(wa) * 2 + int'(lane);
        if (image.exists(ba))
            return image[ba];
        return lane ? (wa[15:8] ^ 8'h5a) : wa[7:0];
    endfunction

    task automatic flag_error(input string msg);
        errors++;
        $display("Fail %0t: %s", $time, msg);
    endtask

    // Enable periods of 2, 4, 6 and 8 clocks
    assert property (@(posedge clk) disable iff (rst24) pxl2_cen |=> !pxl2_cen ##1 pxl2_cen)
        else flag_error("cen12 period");
    assert property (@(posedge clk) disable iff (rst24) pxl_cen |=> !pxl_cen [*3] ##1 pxl_cen)
        else flag_error("cen6 period");
    assert property (@(posedge clk) disable iff (rst24) cen4 |=> !cen4 [*5] ##1 cen4)
        else flag_error("cen4 period");
    assert property (@(posedge clk) disable iff (rst24) cen3 |=> !cen3 [*7] ##1 cen3)
        else flag_error("cen3 period");

    // Download writes, a zero in the mask enables the addressed lane
    assert property (@(posedge clk) disable iff (rst24) dwnld_busy == downloading)
        else flag_error("dwnld_busy differs from downloading");
    assert property (@(posedge clk) disable iff (rst24)
        ioctl_wr && downloading && ioctl_addr < PROM_START |=> prog_we && !prom_we
        && prog_addr == SDRAM_AW'($past(ioctl_addr) >> 1) && prog_data == $past(ioctl_dout)
        && prog_mask == ~(2'b01 << $past(ioctl_addr[0])))
        else flag_error("SDRAM write setup");
    assert property (@(posedge clk) disable iff (rst24) prog_we && !sdram_ack |=> prog_we)
        else flag_error("prog_we dropped before ack");
    assert property (@(posedge clk) disable iff (rst24)
        ioctl_wr && downloading && ioctl_addr >= PROM_START |=> prom_we && !prog_we)
        else flag_error("PROM write strobe");
    assert property (@(posedge clk) disable iff (rst24) prom_we |=> !prom_we)
        else flag_error("prom_we wider than a cycle");
    assert property (@(posedge clk) disable iff (rst24)
        ioctl_wr && downloading && ioctl_addr == '0 |=> tokio == ($past(ioctl_dout) == 8'h7e))
        else flag_error("tokio after byte 0");

    // SDRAM reads and CPU start
    assert property (@(posedge clk) disable iff (rst24) downloading |-> !sdram_req)
        else flag_error("read during download");
    assert property (@(posedge clk) disable iff (rst24)
        sdram_req && !sdram_ack |=> !sdram_req || $stable(sdram_addr))
        else flag_error("sdram_addr moved under a pending read");
    assert property (@(posedge clk) disable iff (rst24)
        $rose(cpu_start) |-> $past(!downloading && ok_vec == 4'hf))
        else flag_error("early cpu_start");
    assert property (@(posedge clk) disable iff (rst24) cpu_start |=> cpu_start)
        else flag_error("cpu_start fell");

    // ROM data against the image or the fill pattern
    assert property (@(posedge clk) disable iff (rst24) main_ok |->
        main_data == exp_byte(MAIN_OFFSET + SDRAM_AW'(main_addr[MAIN_AW-1:1]), main_addr[0]))
        else flag_error($sformatf("main data %h", main_data));
    assert property (@(posedge clk) disable iff (rst24) sub_ok |->
        sub_data == exp_byte(SUB_OFFSET + SDRAM_AW'(sub_addr[SUB_AW-1:1]), sub_addr[0]))
        else flag_error($sformatf("sub data %h", sub_data));
    assert property (@(posedge clk) disable iff (rst24) mcu_ok |->
        mcu_data == exp_byte(MCU_OFFSET + SDRAM_AW'(mcu_addr[MCU_AW-1:1]), mcu_addr[0]))
        else flag_error($sformatf("mcu data %h", mcu_data));
    assert property (@(posedge clk) disable iff (rst24) snd_ok |->
        snd_data == exp_byte(SND_OFFSET + SDRAM_AW'(snd_addr[SND_AW-1:1]), snd_addr[0]))
        else flag_error($sformatf("snd data %h", snd_data));

    task automatic tick;
        @(posedge clk);
        #1;
    endtask

    task automatic write_byte(input logic [IOCTL_AW-1:0] a, input logic [7:0] d);
        int n;
        n = 0;
        if (a < PROM_START)
            image[int'(a)] = d;
        ioctl_addr = a;
        ioctl_dout = d;
        ioctl_wr   = 1'b1;
        tick();
        ioctl_wr = 1'b0;
        tick();
        while (prog_we && n < 100) begin    // Pace to the SDRAM ack
            tick();
            n++;
        end
        if (prog_we) begin
            timeouts++;
            $display("Timeout: SDRAM never acknowledged the write to %h", a);
        end
    endtask

    task automatic download(input logic [7:0] first);
        downloading = 1'b1;
        tick();
        write_byte('0, first);
        for (int i = 1; i < 8; i++)
            write_byte(IOCTL_AW'(i), 8'($random(seed)));
        for (int i = 0; i < 4; i++) begin
            write_byte(IOCTL_AW'(SUB_START) + IOCTL_AW'(i), 8'($random(seed)));
            write_byte(IOCTL_AW'(MCU_START) + IOCTL_AW'(i), 8'($random(seed)));
            write_byte(IOCTL_AW'(SND_START) + IOCTL_AW'(i), 8'($random(seed)));
        end
        write_byte(PROM_START, 8'h11);
        write_byte(PROM_START + 25'd1, 8'h22);
        downloading = 1'b0;
        tick();
        assert (tokio == (first == TOKIO_ID))
            else flag_error($sformatf("tokio is %b", tokio));
    endtask

    // New random addresses on every slot but the held one
    task automatic scramble(input int keep);
        if (keep != 0) main_addr = MAIN_AW'($random(seed)) & 18'h1f;
        if (keep != 1) sub_addr  = SUB_AW'($random(seed)) & 15'h0f;
        if (keep != 2) mcu_addr  = MCU_AW'($random(seed)) & 12'h0f;
        if (keep != 3) snd_addr  = SND_AW'($random(seed)) & 15'h0f;
    endtask

    task automatic random_reads(input int count);
        int n;
        {main_cs, sub_cs, mcu_cs, snd_cs} = 4'hf;
        repeat (count) begin
            scramble(-1);
            n = 0;
            tick();
            while (ok_vec != 4'hf && n < 200) begin
                tick();
                n++;
            end
            if (ok_vec != 4'hf) begin
                timeouts++;
                $display("Timeout: not every slot answered its random address");
            end
        end
    endtask

    // Held slot must be served while the others keep missing
    task automatic hold_one(input int s);
        int n;
        n = 0;
        scramble(-1);
        tick();
        while (!ok_vec[s] && n < 200) begin
            scramble(s);
            tick();
            n++;
        end
        if (!ok_vec[s]) begin
            timeouts++;
            $display("Timeout: slot %0d starved by the other slots", s);
        end
    endtask

    initial begin
        rst24       = 1'b1;
        downloading = 1'b1;             // ROM load follows reset
        ioctl_wr    = 1'b0;
        ioctl_addr  = '0;
        ioctl_dout  = '0;
        {main_cs, sub_cs, mcu_cs, snd_cs} = 4'h0;
        main_addr = '0;
        sub_addr  = '0;
        mcu_addr  = '0;
        snd_addr  = '0;
        repeat (16) @(posedge clk);
        #1 rst24 = 1'b0;
        tick();
        for (int pass = 0; pass < 2; pass++) begin
            {main_cs, sub_cs, mcu_cs, snd_cs} = 4'h0;
            download(pass == 0 ? 8'h7e : 8'h3c);
            for (int n = 0; n < 300 && !cpu_start; n++)
                tick();
            if (!cpu_start) begin
                timeouts++;
                $display("Timeout: CPUs were never started");
            end
            random_reads(100);
            for (int s = 0; s < NSLOTS; s++)
                hold_one(s);
        end
        repeat (10) tick();
        $display("Checks finished with %0d errors and %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* bubl_game.f */
hdl/bubl_pkg.sv
hdl/bubl_cen.sv
hdl/bubl_dwnld.sv
hdl/bubl_rom_slot.sv
hdl/bubl_rom_arb.sv
hdl/bubl_game.sv
testbench/sdram_model.sv
testbench/tb_bubl_game.sv

/* Bender.yml */
package:
  name: bubl_game

sources:
  - hdl/bubl_pkg.sv
  - hdl/bubl_cen.sv
  - hdl/bubl_dwnld.sv
  - hdl/bubl_rom_slot.sv
  - hdl/bubl_rom_arb.sv
  - hdl/bubl_game.sv
  - target: simulation
    files:
      - testbench/sdram_model.sv
      - testbench/tb_bubl_game.sv
